// File: Bender.yml
package:
  name: pcie_rx_top

sources:
  - verilog/pcie_dma_pkg.sv
  - verilog/pcie_mmio_pkg.sv
  - verilog/sync_fifo.sv
  - verilog/head_upd_monitor.sv
  - verilog/meta_merger.sv
  - verilog/pkt_queue_manager.sv
  - verilog/pcie_rx_top.sv
  - target: simulation
    files:
      - sim/tb_pcie_rx_top.sv

// File: sim/tb_pcie_rx_top.sv
`timescale 1ns/1ps

module tb_pcie_rx_top
    import pcie_dma_pkg::*;
    import pcie_mmio_pkg::*;
();

localparam int NB_FLOWS = 16;
localparam int RB_SIZE = 5;
localparam int MAX_CYCLES = 4000;
localparam int RANDOM_PKTS = 80;
localparam int BURST_WRITES = 30;

// All byte enables of the head register and nothing else.
localparam mmio_be_t HEAD_BE = mmio_be_t'({REG_SIZE{1'b1}}) << (HEAD_REG_IDX * REG_SIZE);

typedef enum logic [1:0] {READY_LOW, READY_HIGH, READY_RANDOM} ready_mode_t;

logic        pcie_clk;
logic        pcie_reset_n;
mmio_write_t mmio;
rx_meta_t    rx_meta;
logic        rx_meta_valid;
logic        rx_meta_ready;
rb_ptr_t     pkt_rb_size;
rx_dsc_t     rx_dsc;
logic        rx_dsc_valid;
logic        rx_dsc_ready;
cnt_t        rx_ignored_head_cnt;
cnt_t        rx_pkt_head_upd_cnt;

int          seed = 87735;
int          cycles;
int          fail_count;
int          qual_total;
ready_mode_t ready_mode;
logic        next_ready;

// Reference model of the packet stream and of the per-flow tails.
rx_meta_t    exp_q[$];
rx_meta_t    exp_front;
int          exp_count;
rb_ptr_t     tail_model [NB_FLOWS];
rb_ptr_t     exp_tail;
int          desc_only_total;
int          merged_total;
flow_id_t    last_desc_only_flow;
logic        out_take;

pcie_rx_top #(
    .NB_FLOWS           (NB_FLOWS),
    .HEAD_UPD_QUEUE_LEN (16),
    .IN_QUEUE_LEN       (8)
) i_pcie_rx_top (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .mmio                (mmio),
    .rx_meta             (rx_meta),
    .rx_meta_valid       (rx_meta_valid),
    .rx_meta_ready       (rx_meta_ready),
    .pkt_rb_size         (pkt_rb_size),
    .rx_dsc              (rx_dsc),
    .rx_dsc_valid        (rx_dsc_valid),
    .rx_dsc_ready        (rx_dsc_ready),
    .rx_ignored_head_cnt (rx_ignored_head_cnt),
    .rx_pkt_head_upd_cnt (rx_pkt_head_upd_cnt)
);

initial begin
    pcie_clk = 1'b0;
    forever #4 pcie_clk = ~pcie_clk;
end

task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "Simulation stopped after a failure.");
endtask

task automatic report_error(input string msg);
    fail_count++;
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    stop_with_failure();
endtask

always @(posedge pcie_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
        $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
        stop_with_failure();
    end
end

// Random ready is drawn on the falling edge so it never competes with stimulus draws.
always @(negedge pcie_clk) begin
    next_ready = ($random(seed) & 3) != 0;
end

always @(posedge pcie_clk) begin
    case (ready_mode)
        READY_LOW: rx_dsc_ready <= 1'b0;
        READY_HIGH: rx_dsc_ready <= 1'b1;
        default: rx_dsc_ready <= next_ready;
    endcase
end

assign out_take = rx_dsc_valid && rx_dsc_ready;
assign exp_tail = tail_model[rx_dsc.flow_id];

// Tails advance in output order and wrap at the ring size.
always @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        exp_q.delete();
        exp_count = 0;
        desc_only_total = 0;
        merged_total = 0;
        for (int i = 0; i < NB_FLOWS; i++) begin
            tail_model[i] = '0;
        end
    end else begin
        if (out_take) begin
            if (rx_dsc.descriptor_only) begin
                desc_only_total++;
                last_desc_only_flow = rx_dsc.flow_id;
            end else begin
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
                if (rx_dsc.needs_dsc) begin
                    merged_total++;
                end
                if (int'(tail_model[rx_dsc.flow_id]) + 1 == RB_SIZE) begin
                    tail_model[rx_dsc.flow_id] = '0;
                end else begin
                    tail_model[rx_dsc.flow_id] = tail_model[rx_dsc.flow_id] + 1'b1;
                end
            end
        end
        if (rx_meta_valid && rx_meta_ready) begin
            exp_q.push_back(rx_meta);
        end
        exp_count = exp_q.size();
        if (exp_count > 0) begin
            exp_front = exp_q[0];
        end
    end
end

a_reset_state: assert property (@(posedge pcie_clk)
    $rose(pcie_reset_n) |->
        !rx_dsc_valid && rx_ignored_head_cnt == 0 && rx_pkt_head_upd_cnt == 0)
    else report_error("outputs are not idle right after reset");

a_pkt_order: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    (out_take && !rx_dsc.descriptor_only) |->
        exp_count > 0 && rx_dsc.flow_id == exp_front.flow_id
        && rx_dsc.size == exp_front.size && rx_dsc.dsc_q_id == exp_front.dsc_q_id)
    else report_error("packet descriptor does not match the accepted metadata");

a_tail: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    out_take |-> rx_dsc.tail == exp_tail)
    else report_error("descriptor tail differs from the flow's expected tail");

a_desc_only: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    (out_take && rx_dsc.descriptor_only) |-> rx_dsc.size == '0 && !rx_dsc.needs_dsc)
    else report_error("descriptor-only descriptor has a size or needs_dsc set");

function automatic mmio_addr_t head_addr(input int queue_idx);
    return (mmio_addr_t'(queue_idx) << QUEUE_ID_LSB) | mmio_addr_t'(HEAD_REG_IDX * REG_SIZE);
endfunction

function automatic rx_meta_t rand_meta(input flow_id_t flow);
    rx_meta_t m;
    m.dsc_q_id = dsc_q_id_t'($random(seed));
    m.flow_id = flow;
    m.size = pkt_size_t'($random(seed));
    return m;
endfunction

task automatic set_ready_mode(input ready_mode_t mode);
    @(negedge pcie_clk);
    ready_mode = mode;
    @(posedge pcie_clk);
endtask

task automatic send_meta(input rx_meta_t m);
    @(posedge pcie_clk);
    rx_meta <= m;
    rx_meta_valid <= 1'b1;
    @(negedge pcie_clk);
    while (!rx_meta_ready) begin
        @(negedge pcie_clk);
    end
    @(posedge pcie_clk);
    rx_meta_valid <= 1'b0;
endtask

task automatic write_mmio(input int queue_idx, input mmio_be_t be, input logic wr);
    @(posedge pcie_clk);
    mmio.addr <= head_addr(queue_idx);
    mmio.write <= wr;
    mmio.byteenable <= be;
endtask

task automatic mmio_idle();
    @(posedge pcie_clk);
    mmio.write <= 1'b0;
endtask

// Idle means eight quiet cycles with no packet still owed by the DUT.
task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 8) begin
        @(negedge pcie_clk);
        if (rx_dsc_valid || rx_meta_valid || mmio.write || exp_count != 0) begin
            quiet = 0;
        end else begin
            quiet++;
        end
    end
endtask

task automatic run_random_traffic();
    int gap;
    set_ready_mode(READY_RANDOM);
    for (int n = 0; n < RANDOM_PKTS; n++) begin
        send_meta(rand_meta(flow_id_t'($random(seed) & 7)));
        gap = $random(seed) & 3;
        repeat (gap) @(posedge pcie_clk);
    end
    wait_idle();
endtask

task automatic lone_head_write(input int flow);
    cnt_t upd_before;
    cnt_t ign_before;
    int   dsc_before;
    set_ready_mode(READY_HIGH);
    wait_idle();
    upd_before = rx_pkt_head_upd_cnt;
    ign_before = rx_ignored_head_cnt;
    dsc_before = desc_only_total;
    write_mmio(flow, HEAD_BE, 1'b1);
    qual_total++;
    mmio_idle();
    wait_idle();
    assert (desc_only_total == dsc_before + 1)
        else report_error("lone head write did not give one descriptor-only descriptor");
    assert (last_desc_only_flow == flow_id_t'(flow))
        else report_error("descriptor-only descriptor carries the wrong flow");
    assert (rx_pkt_head_upd_cnt == upd_before + 1)
        else report_error("head update counter did not rise by one");
    assert (rx_ignored_head_cnt == ign_before)
        else report_error("ignored head counter changed on a lone write");
endtask

task automatic filter_writes();
    cnt_t upd_before;
    cnt_t ign_before;
    int   dsc_before;
    upd_before = rx_pkt_head_upd_cnt;
    ign_before = rx_ignored_head_cnt;
    dsc_before = desc_only_total;
    write_mmio(NB_FLOWS, HEAD_BE, 1'b1);
    write_mmio(NB_FLOWS + 9, HEAD_BE, 1'b1);
    write_mmio(2, HEAD_BE & 64'h30, 1'b1);
    write_mmio(3, HEAD_BE & 64'hE0, 1'b1);
    write_mmio(4, HEAD_BE, 1'b0);
    mmio_idle();
    wait_idle();
    assert (desc_only_total == dsc_before)
        else report_error("a filtered write produced a descriptor");
    assert (rx_pkt_head_upd_cnt == upd_before && rx_ignored_head_cnt == ign_before)
        else report_error("a filtered write changed a counter");
endtask

// The head update must be waiting at the merger before the output is released.
task automatic merge_head_and_packet(input int flow);
    cnt_t upd_before;
    int   dsc_before;
    int   merged_before;
    upd_before = rx_pkt_head_upd_cnt;
    dsc_before = desc_only_total;
    merged_before = merged_total;
    set_ready_mode(READY_LOW);
    rx_meta <= rand_meta(flow_id_t'(flow));
    rx_meta_valid <= 1'b1;
    @(negedge pcie_clk);
    while (rx_meta_ready) begin
        @(posedge pcie_clk);
        rx_meta <= rand_meta(flow_id_t'(flow));
        @(negedge pcie_clk);
    end
    write_mmio(flow, HEAD_BE, 1'b1);
    qual_total++;
    mmio_idle();
    @(negedge pcie_clk);
    while (!i_pcie_rx_top.upd_valid) begin
        @(negedge pcie_clk);
    end
    set_ready_mode(READY_HIGH);
    @(negedge pcie_clk);
    while (!rx_meta_ready) begin
        @(negedge pcie_clk);
    end
    @(posedge pcie_clk);
    rx_meta_valid <= 1'b0;
    wait_idle();
    assert (merged_total == merged_before + 1)
        else report_error("head write and packet were not merged");
    assert (desc_only_total == dsc_before)
        else report_error("merged head write also produced a descriptor-only descriptor");
    assert (rx_pkt_head_upd_cnt == upd_before + 1)
        else report_error("merge did not count one head update");
endtask

task automatic overflow_burst();
    cnt_t ign_before;
    ign_before = rx_ignored_head_cnt;
    set_ready_mode(READY_LOW);
    for (int n = 0; n < BURST_WRITES; n++) begin
        write_mmio($unsigned($random(seed)) % NB_FLOWS, HEAD_BE, 1'b1);
        qual_total++;
    end
    mmio_idle();
    set_ready_mode(READY_HIGH);
    wait_idle();
    assert (rx_ignored_head_cnt > ign_before)
        else report_error("burst of head writes did not overflow the head queue");
    assert (rx_ignored_head_cnt + rx_pkt_head_upd_cnt == qual_total)
        else report_error("ignored plus taken head updates differ from qualifying writes");
    assert (desc_only_total + merged_total == rx_pkt_head_upd_cnt)
        else report_error("head update descriptors differ from the head update counter");
endtask

initial begin
    pcie_reset_n = 1'b0;
    mmio = '0;
    rx_meta = '0;
    rx_meta_valid = 1'b0;
    rx_dsc_ready = 1'b0;
    pkt_rb_size = rb_ptr_t'(RB_SIZE);
    ready_mode = READY_HIGH;
    cycles = 0;
    fail_count = 0;
    qual_total = 0;
    repeat (2) @(posedge pcie_clk);
    pcie_reset_n <= 1'b1;

    run_random_traffic();
    lone_head_write(7);
    filter_writes();
    merge_head_and_packet(5);
    overflow_burst();

    if (fail_count == 0) begin
        $display("All tests passed!");
        $finish;
    end else begin
        stop_with_failure();
    end
end

endmodule

// File: tb.f
verilog/pcie_dma_pkg.sv
verilog/pcie_mmio_pkg.sv
verilog/sync_fifo.sv
verilog/head_upd_monitor.sv
verilog/meta_merger.sv
verilog/pkt_queue_manager.sv
verilog/pcie_rx_top.sv
sim/tb_pcie_rx_top.sv

// File: verilog/head_upd_monitor.sv
`timescale 1ns/1ps

module head_upd_monitor
    import pcie_dma_pkg::*;
    import pcie_mmio_pkg::*;
#(
    parameter int NB_FLOWS = 16,
    parameter int HEAD_UPD_QUEUE_LEN = 16
) (
    input  logic            pcie_clk,
    input  logic            pcie_reset_n,
    input  var mmio_write_t mmio,
    output flow_id_t        upd_flow,
    output logic            upd_valid,
    input  logic            upd_ready,
    output cnt_t            ignored_cnt
);

logic [$clog2(HEAD_UPD_QUEUE_LEN)+1:0] queue_occup;
logic       queue_almost_full;
queue_idx_t queue_idx;
logic       head_wr;
flow_id_t   push_flow;
logic       push_valid;

assign queue_idx = mmio.addr[QUEUE_ID_LSB +: QUEUE_IDX_WIDTH];

// Only a full-width write to the head register of an existing queue counts.
always_comb begin
    head_wr = 1'b0;
    if (mmio.write && (queue_idx < NB_FLOWS)) begin
        head_wr = mmio.byteenable[HEAD_REG_IDX*REG_SIZE +: REG_SIZE] == {REG_SIZE{1'b1}};
    end
end

assign queue_almost_full = queue_occup > HEAD_UPD_QUEUE_LEN - 4;

always_ff @(posedge pcie_clk) begin
    push_flow <= queue_idx[FLOW_IDX_WIDTH-1:0];
end

// The host may rewrite a head faster than we drain it. Past the margin the
// update is dropped and only counted.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        push_valid <= 1'b0;
        ignored_cnt <= '0;
    end else begin
        push_valid <= head_wr && !queue_almost_full;
        if (head_wr && queue_almost_full) begin
            ignored_cnt <= ignored_cnt + 1'b1;
        end
    end
end

sync_fifo #(
    .WIDTH ($bits(flow_id_t)),
    .DEPTH (HEAD_UPD_QUEUE_LEN)
) i_head_upd_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (push_flow),
    .in_valid     (push_valid),
    .in_ready     (),
    .out_data     (upd_flow),
    .out_valid    (upd_valid),
    .out_ready    (upd_ready),
    .occup        (queue_occup)
);

endmodule

// File: verilog/meta_merger.sv
`timescale 1ns/1ps

module meta_merger
    import pcie_dma_pkg::*;
#(
    parameter int IN_QUEUE_LEN = 8
) (
    input  logic             pcie_clk,
    input  logic             pcie_reset_n,
    input  flow_id_t         upd_flow,
    input  logic             upd_valid,
    output logic             upd_ready,
    input  var rx_meta_t     rx_meta,
    input  logic             rx_meta_valid,
    output logic             rx_meta_ready,
    output queued_meta_t     q_meta,
    output logic             q_valid,
    input  logic             q_ready,
    output cnt_t             head_upd_cnt
);

logic [$clog2(IN_QUEUE_LEN)+1:0] in_queue_occup;
logic         in_queue_almost_full;
logic         merge;
logic         upd_take;
logic         meta_take;
queued_meta_t entry;
queued_meta_t push_meta;
logic         push_valid;

// Leave room for the entry that is still on its way into the queue.
assign in_queue_almost_full = in_queue_occup > IN_QUEUE_LEN - 4;

// Head updates win over metadata. When the next packet goes to the same
// flow, both are taken together and the packet carries the descriptor.
always_comb begin
    upd_ready = 1'b0;
    rx_meta_ready = 1'b0;
    merge = 1'b0;
    if (!in_queue_almost_full) begin
        upd_ready = 1'b1;
        if (upd_valid) begin
            merge = rx_meta_valid && (rx_meta.flow_id == upd_flow);
            rx_meta_ready = merge;
        end else begin
            rx_meta_ready = 1'b1;
        end
    end
end

assign upd_take = upd_valid & upd_ready;
assign meta_take = rx_meta_valid & rx_meta_ready;

// A head update on its own turns into a descriptor-only entry, which keeps
// it ordered with respect to every packet around it.
always_comb begin
    if (meta_take) begin
        entry.dsc_q_id = rx_meta.dsc_q_id;
        entry.flow_id = rx_meta.flow_id;
        entry.size = rx_meta.size;
        entry.descriptor_only = 1'b0;
        entry.needs_dsc = merge;
    end else begin
        entry.dsc_q_id = '0;
        entry.flow_id = upd_flow;
        entry.size = '0;
        entry.descriptor_only = 1'b1;
        entry.needs_dsc = 1'b0;
    end
end

always_ff @(posedge pcie_clk) begin
    push_meta <= entry;
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        push_valid <= 1'b0;
        head_upd_cnt <= '0;
    end else begin
        push_valid <= upd_take | meta_take;
        if (upd_take) begin
            head_upd_cnt <= head_upd_cnt + 1'b1;
        end
    end
end

sync_fifo #(
    .WIDTH ($bits(queued_meta_t)),
    .DEPTH (IN_QUEUE_LEN)
) i_in_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (push_meta),
    .in_valid     (push_valid),
    .in_ready     (),
    .out_data     (q_meta),
    .out_valid    (q_valid),
    .out_ready    (q_ready),
    .occup        (in_queue_occup)
);

// A merged entry must come from a head update for the very same flow.
assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    (push_valid && push_meta.needs_dsc) |->
        $past(upd_take) && ($past(upd_flow) == push_meta.flow_id))
    else $error("meta_merger: merged entry does not match the head update");

endmodule

// File: verilog/pcie_dma_pkg.sv
package pcie_dma_pkg;

    // Defaults for the flow index and ring-buffer address widths.
    localparam int FLOW_IDX_WIDTH = 4;
    localparam int RB_AWIDTH = 8;

    typedef logic [FLOW_IDX_WIDTH-1:0] flow_id_t;
    typedef logic [1:0] dsc_q_id_t;
    typedef logic [15:0] pkt_size_t;

    // One extra bit so that a full ring can be told apart from an empty one.
    typedef logic [RB_AWIDTH:0] rb_ptr_t;

    typedef logic [31:0] cnt_t;

    // Metadata for a packet arriving from the network side.
    typedef struct packed {
        dsc_q_id_t dsc_q_id;
        flow_id_t  flow_id;
        pkt_size_t size;
    } rx_meta_t;

    // Entry of the input queue in front of the packet queue manager.
    typedef struct packed {
        dsc_q_id_t dsc_q_id;
        flow_id_t  flow_id;
        pkt_size_t size;
        logic      descriptor_only;
        logic      needs_dsc;
    } queued_meta_t;

    // Descriptor handed to the DMA side, with the slot the packet goes to.
    typedef struct packed {
        dsc_q_id_t dsc_q_id;
        flow_id_t  flow_id;
        pkt_size_t size;
        logic      descriptor_only;
        logic      needs_dsc;
        rb_ptr_t   tail;
    } rx_dsc_t;

endpackage

// File: verilog/pcie_mmio_pkg.sv
package pcie_mmio_pkg;

    typedef logic [31:0] mmio_addr_t;
    typedef logic [63:0] mmio_be_t;

    // A single host write as seen on the BAR. The data itself is not needed
    // here, only where it lands and which bytes it touches.
    typedef struct packed {
        mmio_addr_t addr;
        logic       write;
        mmio_be_t   byteenable;
    } mmio_write_t;

    // Every packet queue owns one 4 KB page of registers.
    localparam int QUEUE_ID_LSB = 12;

    // Bytes per register within a queue page.
    localparam int REG_SIZE = 4;

    // The head pointer is the second register of the page.
    localparam int HEAD_REG_IDX = 1;

    localparam int QUEUE_IDX_WIDTH = $bits(mmio_addr_t) - QUEUE_ID_LSB;

    typedef logic [QUEUE_IDX_WIDTH-1:0] queue_idx_t;

endpackage

// File: verilog/pcie_rx_top.sv
`timescale 1ns/1ps

module pcie_rx_top
    import pcie_dma_pkg::*;
    import pcie_mmio_pkg::*;
#(
    parameter int NB_FLOWS = 2**FLOW_IDX_WIDTH,
    parameter int HEAD_UPD_QUEUE_LEN = 16,
    parameter int IN_QUEUE_LEN = 8
) (
    input  logic            pcie_clk,
    input  logic            pcie_reset_n,

    // Host writes to the BAR.
    input  var mmio_write_t mmio,

    input  var rx_meta_t    rx_meta,
    input  logic            rx_meta_valid,
    output logic            rx_meta_ready,

    input  rb_ptr_t         pkt_rb_size,

    output rx_dsc_t         rx_dsc,
    output logic            rx_dsc_valid,
    input  logic            rx_dsc_ready,

    output cnt_t            rx_ignored_head_cnt,
    output cnt_t            rx_pkt_head_upd_cnt
);

flow_id_t     upd_flow;
logic         upd_valid;
logic         upd_ready;
queued_meta_t q_meta;
logic         q_valid;
logic         q_ready;

head_upd_monitor #(
    .NB_FLOWS           (NB_FLOWS),
    .HEAD_UPD_QUEUE_LEN (HEAD_UPD_QUEUE_LEN)
) i_head_upd_monitor (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .mmio         (mmio),
    .upd_flow     (upd_flow),
    .upd_valid    (upd_valid),
    .upd_ready    (upd_ready),
    .ignored_cnt  (rx_ignored_head_cnt)
);

meta_merger #(
    .IN_QUEUE_LEN (IN_QUEUE_LEN)
) i_meta_merger (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .upd_flow      (upd_flow),
    .upd_valid     (upd_valid),
    .upd_ready     (upd_ready),
    .rx_meta       (rx_meta),
    .rx_meta_valid (rx_meta_valid),
    .rx_meta_ready (rx_meta_ready),
    .q_meta        (q_meta),
    .q_valid       (q_valid),
    .q_ready       (q_ready),
    .head_upd_cnt  (rx_pkt_head_upd_cnt)
);

pkt_queue_manager #(
    .NB_FLOWS (NB_FLOWS)
) i_pkt_queue_manager (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .pkt_rb_size  (pkt_rb_size),
    .q_meta       (q_meta),
    .q_valid      (q_valid),
    .q_ready      (q_ready),
    .rx_dsc       (rx_dsc),
    .rx_dsc_valid (rx_dsc_valid),
    .rx_dsc_ready (rx_dsc_ready)
);

endmodule

// File: verilog/pkt_queue_manager.sv
`timescale 1ns/1ps

module pkt_queue_manager
    import pcie_dma_pkg::*;
#(
    parameter int NB_FLOWS = 16
) (
    input  logic             pcie_clk,
    input  logic             pcie_reset_n,
    input  rb_ptr_t          pkt_rb_size,
    input  var queued_meta_t q_meta,
    input  logic             q_valid,
    output logic             q_ready,
    output rx_dsc_t          rx_dsc,
    output logic             rx_dsc_valid,
    input  logic             rx_dsc_ready
);

rb_ptr_t tails [NB_FLOWS];
rb_ptr_t cur_tail;
rb_ptr_t inc_tail;
rb_ptr_t next_tail;
logic    take;

// The output register frees up in the same cycle it is read.
assign q_ready = !rx_dsc_valid || rx_dsc_ready;
assign take = q_valid && q_ready;

assign cur_tail = tails[q_meta.flow_id];
assign inc_tail = cur_tail + 1'b1;
assign next_tail = (inc_tail >= pkt_rb_size) ? '0 : inc_tail;

always_ff @(posedge pcie_clk) begin
    if (take) begin
        rx_dsc.dsc_q_id <= q_meta.dsc_q_id;
        rx_dsc.flow_id <= q_meta.flow_id;
        rx_dsc.size <= q_meta.size;
        rx_dsc.descriptor_only <= q_meta.descriptor_only;
        rx_dsc.needs_dsc <= q_meta.needs_dsc;
        rx_dsc.tail <= cur_tail;
    end
end

// A descriptor-only entry reports the tail but takes no slot in the ring.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        for (int i = 0; i < NB_FLOWS; i++) begin
            tails[i] <= '0;
        end
        rx_dsc_valid <= 1'b0;
    end else begin
        if (take && !q_meta.descriptor_only) begin
            tails[q_meta.flow_id] <= next_tail;
        end
        if (take) begin
            rx_dsc_valid <= 1'b1;
        end else if (rx_dsc_ready) begin
            rx_dsc_valid <= 1'b0;
        end
    end
end

// A stalled descriptor must not change under the consumer.
assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    (rx_dsc_valid && !rx_dsc_ready) |=> rx_dsc_valid && $stable(rx_dsc))
    else $error("pkt_queue_manager: descriptor changed while stalled");

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                     pcie_clk,
    input  logic                     pcie_reset_n,
    input  logic [WIDTH-1:0]         in_data,
    input  logic                     in_valid,
    output logic                     in_ready,
    output logic [WIDTH-1:0]         out_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [$clog2(DEPTH)+1:0] occup
);

localparam int AW = $clog2(DEPTH);
localparam int OW = AW + 2;

logic [WIDTH-1:0] mem [DEPTH];
logic [AW-1:0]    wr_ptr;
logic [AW-1:0]    rd_ptr;
logic [AW:0]      mem_cnt;
logic             push;
logic             load;

assign in_ready = (mem_cnt != DEPTH);
assign push = in_valid & in_ready;

// The output register refills from memory whenever it is empty or drained.
assign load = (mem_cnt != 0) && (!out_valid || out_ready);

// Entries in memory plus the one waiting in the output register.
assign occup = OW'(mem_cnt) + OW'(out_valid);

always_ff @(posedge pcie_clk) begin
    if (push) begin
        mem[wr_ptr] <= in_data;
    end
    if (load) begin
        out_data <= mem[rd_ptr];
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        mem_cnt <= '0;
        out_valid <= 1'b0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (load) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end

        case ({push, load})
            2'b10: mem_cnt <= mem_cnt + 1'b1;
            2'b01: mem_cnt <= mem_cnt - 1'b1;
            default: mem_cnt <= mem_cnt;
        endcase

        if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end
end

// Writers keep their own almost-full margin, so a push never meets a full queue.
assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    in_valid |-> in_ready)
    else $error("sync_fifo: push while the queue is full");

// A pop from an empty memory would wrap the count past DEPTH.
assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    mem_cnt <= DEPTH)
    else $error("sync_fifo: occupancy count out of range after a pop");

endmodule
